//--- microCpu.f
verilog/microPkg.sv
verilog/microCtrlIf.sv
verilog/microSequencer.sv
verilog/controlStore.sv
verilog/microDatapath.sv
verilog/microCpu.sv
verification/microCpu_chk.sv
verification/microCpuTb.sv

//--- verification/microCpuTb.sv
// Testbench for the microprogrammed CPU
// Clock, reset, fixed and random instruction streams, error summary
module microCpuTb;
        timeunit 1ns;
        timeprecision 1ps;

        // Cycles allowed for any single wait
        localparam int maxWait = 40;

        logic       clk, rstN, go, instrValid;
        logic       instrTake, outStrobe, halted;
        logic [7:0] instr, dataIn, dataOut;
        integer     seed;
        int         timeouts;

        // Directed stream with IN reading 8'hFE
        logic [7:0] fixedProg [35] = '{
                8'h15, 8'h80, 8'h3F, 8'h80,
                // Carry chain into ADC and SHL carry out
                8'h20, 8'h33, 8'hB0, 8'h80,
                8'h20, 8'h93, 8'hB1, 8'h80,
                // SUB without and with borrow
                8'h73, 8'h15, 8'h77, 8'h80,
                8'h4F, 8'h51, 8'h65, 8'h80,
                // Zero set so LDI and then OUT are dropped
                8'h10, 8'hA0, 8'h17, 8'h80,
                8'hA0, 8'h80,
                // Zero clear leaves SKIPZ without effect
                8'h13, 8'hA0, 8'h31, 8'h80,
                8'h00, 8'hC0, 8'hD0, 8'hE0, 8'h80
        };

        microCpu dut_i (.*);

        always #10 clk = ~clk;

        // Present one instruction and hold it until taken
        task automatic sendInstr(input logic [7:0] word, input logic [7:0] inValue);
                int waited;
                @(posedge clk);
                #2;
                instr      = word;
                instrValid = 1'b1;
                // dataIn only changes with an IN
                if (word[7:4] == microPkg::opIn)
                        dataIn = inValue;
                waited = 0;
                @(negedge clk);
                while (!instrTake && waited < maxWait) begin
                        @(negedge clk);
                        waited++;
                end
                if (!instrTake) begin
                        timeouts++;
                        $display("timeout at %0t: instruction %h was never taken", $time, word);
                end
                @(posedge clk);
                #2;
                instrValid = 1'b0;
                // Idle gap so the fetch has to wait for valid
                repeat ($unsigned($random(seed)) % 3) @(posedge clk);
        endtask

        initial begin
                int         waited;
                logic [7:0] word;
                clk        = 1'b0;
                rstN       = 1'b0;
                go         = 1'b0;
                instrValid = 1'b0;
                instr      = 8'h00;
                dataIn     = 8'h00;
                seed       = 13;
                timeouts   = 0;
                repeat (8) @(posedge clk);
                #2;
                rstN = 1'b1;
                // Idle with go low and an instruction already offered
                instr      = fixedProg[0];
                instrValid = 1'b1;
                repeat (6) @(posedge clk);
                #2;
                go = 1'b1;
                foreach (fixedProg[i])
                        sendInstr(fixedProg[i], 8'hFE);
                // Random groups each closed by OUT
                repeat (30) begin
                        repeat (1 + $unsigned($random(seed)) % 3) begin
                                word = $random(seed);
                                // HALT would end the run early
                                if (word[7:4] == microPkg::opHalt)
                                        word[7:4] = microPkg::opAdc;
                                sendInstr(word, $random(seed));
                        end
                        sendInstr({microPkg::opOut, 4'h0}, 8'h00);
                end
                sendInstr({microPkg::opHalt, 4'h0}, 8'h00);
                waited = 0;
                while (!halted && waited < maxWait) begin
                        @(negedge clk);
                        waited++;
                end
                if (!halted) begin
                        timeouts++;
                        $display("timeout at %0t: halted never went high", $time);
                end
                // Work still offered after halt
                @(posedge clk);
                #2;
                instr      = 8'h15;
                instrValid = 1'b1;
                repeat (10) @(posedge clk);
                @(negedge clk);
                $display("errors: %0d assertion failures, %0d timeouts",
                         dut_i.chk_i.failCount, timeouts);
                if (dut_i.chk_i.failCount + timeouts == 0)
                        $display(">>> PASS");
                else
                        $display(">>> FAIL");
                $finish;
        end

endmodule

//--- verification/microCpu_chk.sv
// Bound checker with an accumulator reference model
// Concurrent assertions on output values, carry, take and strobe pulses, halt
module microCpuChk (
        input logic       clk, rstN, go, instrValid, instrTake, outStrobe, halted,
        input logic       carryFlag,
        input logic [7:0] instr, dataIn, dataOut
);
        timeunit 1ns;
        timeprecision 1ps;

        // Assertion failures so far
        int         failCount = 0;
        logic [7:0] mAcc;
        logic [7:0] imm;
        logic [9:0] step;
        logic       mZero, mCarry, mSkip, goSeen;

        assign imm = {4'h0, instr[3:0]};

        // {acc write, carry, acc} for the instruction on the port
        always_comb begin
                case (microPkg::opcodeE'(instr[7:4]))
                        microPkg::opLdi: step = {2'b10, imm};
                        microPkg::opIn:  step = {2'b10, dataIn};
                        microPkg::opAdd: step = {1'b1, {1'b0, mAcc} + {1'b0, imm}};
                        // Carry means no borrow
                        microPkg::opSub: step = {1'b1, mAcc >= imm, mAcc - imm};
                        microPkg::opAnd: step = {2'b10, mAcc & imm};
                        microPkg::opOr:  step = {2'b10, mAcc | imm};
                        microPkg::opXor: step = {2'b10, mAcc ^ imm};
                        microPkg::opShl: step = {1'b1, mAcc, 1'b0};
                        microPkg::opAdc:
                                step = {1'b1, {1'b0, mAcc} + {1'b0, imm} + {8'h00, mCarry}};
                        // OUT, SKIPZ, HALT and NOPs leave A alone
                        default:         step = 10'h000;
                endcase
        end

        always_ff @(posedge clk) begin
                if (!rstN) begin
                        {mAcc, mZero, mCarry, mSkip, goSeen} <= '0;
                end else begin
                        goSeen <= goSeen | go;
                        if (instrTake) begin
                                // Instruction after a SKIPZ on zero is dropped
                                mSkip <= 1'b0;
                                if (!mSkip && step[9]) begin
                                        mCarry <= step[8];
                                        mAcc   <= step[7:0];
                                        mZero  <= (step[7:0] == 8'h00);
                                end
                                if (!mSkip && instr[7:4] == microPkg::opSkpz)
                                        mSkip <= mZero;
                        end
                end
        end

        task automatic countFailure(input string msg);
                failCount++;
                $error("%s", msg);
        endtask

        // Nothing moves before go
        assert property (@(posedge clk) disable iff (!rstN)
                !goSeen |-> !(instrTake || outStrobe || halted))
                else countFailure($sformatf("output active before go at %0t", $time));
        // OUT shows the model accumulator
        assert property (@(posedge clk) disable iff (!rstN) outStrobe |-> dataOut == mAcc)
                else countFailure($sformatf("mismatch at %0t: dataOut %h, expected %h",
                                            $time, $sampled(dataOut), $sampled(mAcc)));
        // Carry flag agrees with the model at each output
        assert property (@(posedge clk) disable iff (!rstN) outStrobe |-> carryFlag == mCarry)
                else countFailure($sformatf("mismatch at %0t: carryFlag %b, expected %b",
                                            $time, $sampled(carryFlag), $sampled(mCarry)));
        // Take is a single cycle and only while valid
        assert property (@(posedge clk) disable iff (!rstN)
                instrTake |-> instrValid ##1 !instrTake)
                else countFailure($sformatf("bad instrTake pulse at %0t", $time));
        assert property (@(posedge clk) disable iff (!rstN) outStrobe |=> !outStrobe)
                else countFailure($sformatf("outStrobe longer than one cycle at %0t", $time));
        // Halt is final
        assert property (@(posedge clk) disable iff (!rstN)
                halted |-> (!instrTake && !outStrobe) ##1 halted)
                else countFailure($sformatf("activity or release after halt at %0t", $time));

endmodule

// One checker per CPU instance
bind microCpu microCpuChk chk_i (.*);

//--- verilog/controlStore.sv
// Microcode ROM (256 x 24) and microinstruction register
// Idle, fetch, decode, per-opcode routines, skip and halt loop
module controlStore (
        input  logic                clk,
        input  logic                rstN,
        input  microPkg::microAddrT microAddr,
        microCtrlIf.src             ctrl
);

        microPkg::microWordT romWord;
        microPkg::microWordT mir;

        // Assemble one microword
        function automatic microPkg::microWordT mw(
                input microPkg::destE      dst,
                input microPkg::aluOpE     func,
                input logic                aSrc,
                input logic                bSrc,
                input logic                cinSrc,
                input microPkg::branchOpE  branch,
                input logic                cnt,
                input microPkg::microAddrT target
        );
                microPkg::microWordT w;
                w = '{dest: dst, cinSel: cinSrc, aluFunc: func, bSel: bSrc, aSel: aSrc,
                      bop: branch, count: cnt, nextAddr: target};
                return w;
        endfunction

        always_comb begin
                case (microAddr)
                        // Wait for go
                        microPkg::addrIdle:
                                romWord = mw(microPkg::destNone, microPkg::aluPassA, 1'b0, 1'b0,
                                             1'b0, microPkg::bopIfGo, 1'b0, microPkg::addrFetch);
                        // Wait for a valid instruction
                        microPkg::addrFetch:
                                romWord = mw(microPkg::destNone, microPkg::aluPassA, 1'b0, 1'b0,
                                             1'b0, microPkg::bopIfValid, 1'b0,
                                             microPkg::addrDecode);
                        // Take into IR and dispatch on its opcode
                        microPkg::addrDecode:
                                romWord = mw(microPkg::destIr, microPkg::aluPassA, 1'b0, 1'b0,
                                             1'b0, microPkg::bopDispatch, 1'b1,
                                             microPkg::addrFetch);
                        // Halt loop, parked for good
                        microPkg::addrHalt:
                                romWord = mw(microPkg::destNone, microPkg::aluPassA, 1'b0, 1'b0,
                                             1'b0, microPkg::bopNever, 1'b0, microPkg::addrHalt);
                        // Skip: wait for the next instruction
                        microPkg::addrSkip:
                                romWord = mw(microPkg::destNone, microPkg::aluPassA, 1'b0, 1'b0,
                                             1'b0, microPkg::bopIfValid, 1'b0, 8'h13);
                        // Take it and drop it
                        8'h13:
                                romWord = mw(microPkg::destIr, microPkg::aluPassA, 1'b0, 1'b0,
                                             1'b0, microPkg::bopAlways, 1'b1, microPkg::addrFetch);
                        // NOP and the spare opcodes
                        {microPkg::opNop, 4'h1}, {microPkg::opRsvC, 4'h1},
                        {microPkg::opRsvD, 4'h1}, {microPkg::opRsvE, 4'h1}:
                                romWord = mw(microPkg::destNone, microPkg::aluPassA, 1'b0, 1'b0,
                                             1'b0, microPkg::bopAlways, 1'b1, microPkg::addrFetch);
                        // Immediate into A
                        {microPkg::opLdi, 4'h1}:
                                romWord = mw(microPkg::destAcc, microPkg::aluPassB, 1'b0, 1'b0,
                                             1'b0, microPkg::bopAlways, 1'b1, microPkg::addrFetch);
                        // dataIn into A
                        {microPkg::opIn, 4'h1}:
                                romWord = mw(microPkg::destAcc, microPkg::aluPassA, 1'b1, 1'b0,
                                             1'b0, microPkg::bopAlways, 1'b1, microPkg::addrFetch);
                        {microPkg::opAdd, 4'h1}:
                                romWord = mw(microPkg::destAcc, microPkg::aluAdd, 1'b0, 1'b0,
                                             1'b0, microPkg::bopAlways, 1'b1, microPkg::addrFetch);
                        {microPkg::opAnd, 4'h1}:
                                romWord = mw(microPkg::destAcc, microPkg::aluAnd, 1'b0, 1'b0,
                                             1'b0, microPkg::bopAlways, 1'b1, microPkg::addrFetch);
                        {microPkg::opOr, 4'h1}:
                                romWord = mw(microPkg::destAcc, microPkg::aluOr, 1'b0, 1'b0,
                                             1'b0, microPkg::bopAlways, 1'b1, microPkg::addrFetch);
                        {microPkg::opXor, 4'h1}:
                                romWord = mw(microPkg::destAcc, microPkg::aluXor, 1'b0, 1'b0,
                                             1'b0, microPkg::bopAlways, 1'b1, microPkg::addrFetch);
                        // Carry in forced by the ALU
                        {microPkg::opSub, 4'h1}:
                                romWord = mw(microPkg::destAcc, microPkg::aluSub, 1'b0, 1'b0,
                                             1'b0, microPkg::bopAlways, 1'b1, microPkg::addrFetch);
                        // A through the ALU into the output register
                        {microPkg::opOut, 4'h1}:
                                romWord = mw(microPkg::destOut, microPkg::aluPassA, 1'b0, 1'b0,
                                             1'b0, microPkg::bopAlways, 1'b1, microPkg::addrFetch);
                        {microPkg::opShl, 4'h1}:
                                romWord = mw(microPkg::destAcc, microPkg::aluShl, 1'b0, 1'b0,
                                             1'b0, microPkg::bopAlways, 1'b1, microPkg::addrFetch);
                        // Zero set goes to skip, else falls through
                        {microPkg::opSkpz, 4'h1}:
                                romWord = mw(microPkg::destNone, microPkg::aluPassA, 1'b0, 1'b0,
                                             1'b0, microPkg::bopIfZero, 1'b1, microPkg::addrSkip);
                        {microPkg::opSkpz, 4'h2}:
                                romWord = mw(microPkg::destNone, microPkg::aluPassA, 1'b0, 1'b0,
                                             1'b0, microPkg::bopAlways, 1'b1, microPkg::addrFetch);
                        // Add with carry flag in
                        {microPkg::opAdc, 4'h1}:
                                romWord = mw(microPkg::destAcc, microPkg::aluAdd, 1'b0, 1'b0,
                                             1'b1, microPkg::bopAlways, 1'b1, microPkg::addrFetch);
                        {microPkg::opHalt, 4'h1}:
                                romWord = mw(microPkg::destHalt, microPkg::aluPassA, 1'b0, 1'b0,
                                             1'b0, microPkg::bopAlways, 1'b1, microPkg::addrHalt);
                        // Unused words restart at idle
                        default:
                                romWord = mw(microPkg::destNone, microPkg::aluPassA, 1'b0, 1'b0,
                                             1'b0, microPkg::bopAlways, 1'b1, microPkg::addrIdle);
                endcase
        end

        // Microinstruction register
        always_ff @(posedge clk) begin
                if (!rstN)
                        mir <= microPkg::resetWord;
                else
                        mir <= romWord;
        end

        assign ctrl.nextAddr = mir.nextAddr;
        assign ctrl.count    = mir.count;
        assign ctrl.bop      = mir.bop;
        assign ctrl.aSel     = mir.aSel;
        assign ctrl.bSel     = mir.bSel;
        assign ctrl.aluFunc  = mir.aluFunc;
        assign ctrl.cinSel   = mir.cinSel;
        assign ctrl.dest     = mir.dest;

endmodule

//--- verilog/microCpu.sv
// Top level of the microprogrammed CPU
// Sequencer, control store and datapath on one control bus
module microCpu (
        input  logic                       clk,
        input  logic                       rstN,
        input  logic                       go,
        input  logic                       instrValid,
        input  logic [microPkg::dataW-1:0] instr,
        input  logic [microPkg::dataW-1:0] dataIn,
        output logic                       instrTake,
        output logic [microPkg::dataW-1:0] dataOut,
        output logic                       outStrobe,
        output logic                       halted
);

        // Current microword fields
        microCtrlIf ctrlBus ();

        microPkg::microAddrT microAddr;
        microPkg::opcodeE    opcode;
        logic                zeroFlag;
        // Only leaves the datapath for observation
        logic                carryFlag;

        microSequencer sequencer (
                .clk        (clk),
                .rstN       (rstN),
                .ctrl       (ctrlBus.seq),
                .go         (go),
                .instrValid (instrValid),
                .zeroFlag   (zeroFlag),
                .opcode     (opcode),
                .microAddr  (microAddr)
        );

        controlStore ctrlStore (
                .clk        (clk),
                .rstN       (rstN),
                .microAddr  (microAddr),
                .ctrl       (ctrlBus.src)
        );

        microDatapath datapath (
                .clk        (clk),
                .rstN       (rstN),
                .ctrl       (ctrlBus.exe),
                .instr      (instr),
                .dataIn     (dataIn),
                .opcode     (opcode),
                .zeroFlag   (zeroFlag),
                .carryFlag  (carryFlag),
                .instrTake  (instrTake),
                .dataOut    (dataOut),
                .outStrobe  (outStrobe),
                .halted     (halted)
        );

endmodule

//--- verilog/microCtrlIf.sv
// Decoded fields of the current microinstruction
// Producer, sequencer and datapath modports
interface microCtrlIf;

        // Sequencing fields
        microPkg::microAddrT nextAddr;
        logic                count;
        microPkg::branchOpE  bop;

        // Datapath fields
        logic                aSel;
        logic                bSel;
        microPkg::aluOpE     aluFunc;
        logic                cinSel;
        microPkg::destE      dest;

        // Microinstruction register side
        modport src (
                output nextAddr, count, bop,
                output aSel, bSel, aluFunc, cinSel, dest
        );

        modport seq (
                input nextAddr, count, bop
        );

        modport exe (
                input aSel, bSel, aluFunc, cinSel, dest
        );

endinterface

//--- verilog/microDatapath.sv
// Accumulator datapath: IR, ALU, zero/carry flags
// Output register with strobe, halted bit
module microDatapath (
        input  logic                        clk,
        input  logic                        rstN,
        microCtrlIf.exe                     ctrl,
        input  logic [microPkg::dataW-1:0]  instr,
        input  logic [microPkg::dataW-1:0]  dataIn,
        output microPkg::opcodeE            opcode,
        output logic                        zeroFlag,
        output logic                        carryFlag,
        output logic                        instrTake,
        output logic [microPkg::dataW-1:0]  dataOut,
        output logic                        outStrobe,
        output logic                        halted
);

        logic [microPkg::dataW-1:0] ir;
        logic [microPkg::dataW-1:0] acc;
        logic [microPkg::dataW-1:0] aOp;
        logic [microPkg::dataW-1:0] bOp;
        logic [microPkg::dataW-1:0] aluRes;
        logic [microPkg::dataW:0]   sum;
        logic                       aluCarry;
        logic                       cin;
        logic                       isSub;

        assign instrTake = (ctrl.dest == microPkg::destIr);

        // Opcode bypasses IR in the take cycle so decode can dispatch at once
        assign opcode = microPkg::opcodeE'(instrTake ? instr[7:4] : ir[7:4]);

        // Operand select
        assign aOp = ctrl.aSel ? dataIn : acc;
        assign bOp = ctrl.bSel ? '0 : {4'h0, ir[3:0]};

        // SUB is A + ~B + 1, carry out means no borrow
        assign isSub = (ctrl.aluFunc == microPkg::aluSub);
        assign cin   = isSub | (ctrl.cinSel & carryFlag);
        assign sum   = {1'b0, aOp} + {1'b0, (isSub ? ~bOp : bOp)} + {8'h00, cin};

        always_comb begin
                aluCarry = 1'b0;
                case (ctrl.aluFunc)
                        microPkg::aluPassA: aluRes = aOp;
                        microPkg::aluPassB: aluRes = bOp;
                        microPkg::aluAdd,
                        microPkg::aluSub: {aluCarry, aluRes} = sum;
                        microPkg::aluAnd: aluRes = aOp & bOp;
                        microPkg::aluOr:  aluRes = aOp | bOp;
                        microPkg::aluXor: aluRes = aOp ^ bOp;
                        // Bit 7 shifts out into carry
                        microPkg::aluShl: {aluCarry, aluRes} = {aOp, 1'b0};
                        default:          aluRes = aOp;
                endcase
        end

        // Instruction register
        always_ff @(posedge clk) begin
                if (instrTake)
                        ir <= instr;
        end

        // Accumulator, flags, output and halt
        always_ff @(posedge clk) begin
                if (!rstN) begin
                        acc       <= '0;
                        zeroFlag  <= 1'b0;
                        carryFlag <= 1'b0;
                        dataOut   <= '0;
                        outStrobe <= 1'b0;
                        halted    <= 1'b0;
                end else begin
                        // One cycle after the OUT word
                        outStrobe <= (ctrl.dest == microPkg::destOut);
                        case (ctrl.dest)
                                microPkg::destAcc: begin
                                        acc       <= aluRes;
                                        zeroFlag  <= (aluRes == '0);
                                        carryFlag <= aluCarry;
                                end
                                microPkg::destOut:  dataOut <= aluRes;
                                // Sticky until reset
                                microPkg::destHalt: halted  <= 1'b1;
                                default: ;
                        endcase
                end
        end

endmodule

//--- verilog/microPkg.sv
// Shared definitions for the microprogrammed CPU
// Microword layout, branch/ALU/destination/opcode enums, microcode addresses
package microPkg;

        // Data and microcode address widths
        localparam int dataW = 8;
        localparam int addrW = 8;

        typedef logic [addrW-1:0] microAddrT;

        // Next address selection
        typedef enum logic [3:0] {
                bopNever    = 4'h0,
                bopAlways   = 4'h1,
                bopIfGo     = 4'h2,
                bopIfValid  = 4'h3,
                bopIfZero   = 4'h4,
                bopDispatch = 4'h5
        } branchOpE;

        typedef enum logic [4:0] {
                aluPassA = 5'h00,
                aluPassB = 5'h01,
                aluAdd   = 5'h02,
                aluSub   = 5'h03,
                aluAnd   = 5'h04,
                aluOr    = 5'h05,
                aluXor   = 5'h06,
                aluShl   = 5'h07
        } aluOpE;

        // Where the ALU result goes
        typedef enum logic [2:0] {
                destNone = 3'h0,
                destAcc  = 3'h1,
                destIr   = 3'h2,
                destOut  = 3'h3,
                destHalt = 3'h4
        } destE;

        // Macro opcodes, C to E run as NOP
        typedef enum logic [3:0] {
                opNop  = 4'h0, opLdi  = 4'h1, opIn   = 4'h2, opAdd  = 4'h3,
                opAnd  = 4'h4, opOr   = 4'h5, opXor  = 4'h6, opSub  = 4'h7,
                opOut  = 4'h8, opShl  = 4'h9, opSkpz = 4'hA, opAdc  = 4'hB,
                opRsvC = 4'hC, opRsvD = 4'hD, opRsvE = 4'hE, opHalt = 4'hF
        } opcodeE;

        // 24-bit microword, MSB first
        typedef struct packed {
                destE      dest;
                logic      cinSel;
                aluOpE     aluFunc;
                logic      bSel;
                logic      aSel;
                branchOpE  bop;
                logic      count;
                microAddrT nextAddr;
        } microWordT;

        // Fixed entry points
        localparam microAddrT addrIdle   = 8'h00;
        localparam microAddrT addrFetch  = 8'h0E;
        localparam microAddrT addrDecode = 8'h0F;
        localparam microAddrT addrHalt   = 8'h10;
        localparam microAddrT addrSkip   = 8'h12;

        // Held by the microinstruction register out of reset
        localparam microWordT resetWord = '{
                dest: destNone, cinSel: 1'b0, aluFunc: aluPassA, bSel: 1'b0,
                aSel: 1'b0, bop: bopAlways, count: 1'b0, nextAddr: addrIdle
        };

endpackage

//--- verilog/microSequencer.sv
// Micro program counter and next-address selection
module microSequencer (
        input  logic                clk,
        input  logic                rstN,
        microCtrlIf.seq             ctrl,
        input  logic                go,
        input  logic                instrValid,
        input  logic                zeroFlag,
        input  microPkg::opcodeE    opcode,
        output microPkg::microAddrT microAddr
);

        // Address of the word now in the microinstruction register
        microPkg::microAddrT upc;
        logic                taken;

        // Branch condition
        always_comb begin
                case (ctrl.bop)
                        microPkg::bopNever:    taken = 1'b0;
                        microPkg::bopAlways:   taken = 1'b1;
                        microPkg::bopIfGo:     taken = go;
                        microPkg::bopIfValid:  taken = instrValid;
                        microPkg::bopIfZero:   taken = zeroFlag;
                        microPkg::bopDispatch: taken = 1'b1;
                        default:               taken = 1'b0;
                endcase
        end

        // Next address
        // Dispatch lands on the opcode's row at offset 1
        always_comb begin
                if (taken) begin
                        if (ctrl.bop == microPkg::bopDispatch)
                                microAddr = {opcode, 4'h1};
                        else
                                microAddr = ctrl.nextAddr;
                end else if (ctrl.count) begin
                        microAddr = upc + 8'd1;
                end else begin
                        // Count 0 repeats the word, wait loop
                        microAddr = upc;
                end
        end

        // ROM sees the next address, so upc tracks the registered word
        always_ff @(posedge clk) begin
                if (!rstN)
                        upc <= microPkg::addrIdle;
                else
                        upc <= microAddr;
        end

endmodule
